//--- src/box_pkg.sv
package box_pkg;

  // width of one channel pixel
  localparam int PIX_W = 8;

  // cycles between start and the first row load
  // gives the frame buffer time to switch frames
  localparam int WARMUP_CYCLES = 3;

  // sequencer states, one frame per pass from IDLE back to IDLE
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    WARMUP   = 3'd1,
    ROW_LOAD = 3'd2,
    FILL     = 3'd3,
    SLIDE    = 3'd4,
    FINISH   = 3'd5,
    DONE     = 3'd6
  } seq_state_t;

endpackage

//--- src/row_sequencer.sv
module row_sequencer #(
  parameter int COLS = 16,
  parameter int ROWS = 4,
  parameter int WIN  = 4,
  localparam int COL_W = $clog2(COLS)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_start,
  input  logic             i_warm_done,
  input  logic [COL_W-1:0] i_col,
  input  logic             i_last_row,
  output logic             o_warm_en,
  output logic             o_col_en,
  output logic             o_row_load,
  output logic             o_fill,
  output logic             o_slide,
  output logic             o_row_last_col,
  output logic             o_frame_done
);

  box_pkg::seq_state_t state;
  box_pkg::seq_state_t next_state;

  // window must fit inside one row
  if (WIN < 2 || WIN > COLS || ROWS < 1) begin : g_bad_cfg
    $error("row_sequencer: need 2 <= WIN <= COLS and ROWS >= 1");
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= box_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      // start is only taken here, so a pulse mid-frame is dropped
      box_pkg::IDLE: begin
        if (i_start) begin
          next_state = box_pkg::WARMUP;
        end
      end
      box_pkg::WARMUP: begin
        if (i_warm_done) begin
          next_state = box_pkg::ROW_LOAD;
        end
      end
      box_pkg::ROW_LOAD: begin
        next_state = box_pkg::FILL;
      end
      // columns 0 .. WIN-2 only prime the window
      box_pkg::FILL: begin
        if (i_col == COL_W'(WIN - 2)) begin
          next_state = box_pkg::SLIDE;
        end
      end
      box_pkg::SLIDE: begin
        if (i_col == COL_W'(COLS - 1)) begin
          next_state = i_last_row ? box_pkg::FINISH : box_pkg::ROW_LOAD;
        end
      end
      box_pkg::FINISH: begin
        next_state = box_pkg::DONE;
      end
      box_pkg::DONE: begin
        next_state = box_pkg::IDLE;
      end
      default: begin
        next_state = box_pkg::IDLE;
      end
    endcase
  end

  assign o_warm_en      = (state == box_pkg::WARMUP);
  assign o_row_load     = (state == box_pkg::ROW_LOAD);
  assign o_fill         = (state == box_pkg::FILL);
  assign o_slide        = (state == box_pkg::SLIDE);
  // one read per cycle in both fill and slide
  assign o_col_en       = o_fill | o_slide;
  assign o_row_last_col = o_slide && (i_col == COL_W'(COLS - 1));
  assign o_frame_done   = (state == box_pkg::FINISH);

  a_done_in_finish : assert property (@(posedge clk) disable iff (!rst_n)
    o_frame_done |-> (state == box_pkg::FINISH) && $past(state == box_pkg::SLIDE));

  a_fill_slide_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(o_fill && o_slide));

  a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
    state inside {box_pkg::IDLE, box_pkg::WARMUP, box_pkg::ROW_LOAD, box_pkg::FILL,
                  box_pkg::SLIDE, box_pkg::FINISH, box_pkg::DONE});

endmodule

//--- src/scan_counter.sv
module scan_counter #(
  parameter int COLS = 16,
  parameter int ROWS = 4,
  localparam int COL_W  = $clog2(COLS),
  localparam int ADDR_W = $clog2(ROWS * COLS)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_warm_en,
  input  logic              i_col_en,
  input  logic              i_row_load,
  output logic              o_warm_done,
  output logic [COL_W-1:0]  o_col,
  output logic              o_last_row,
  output logic [ADDR_W-1:0] o_rd_addr
);

  localparam int WARM_W = $clog2(box_pkg::WARMUP_CYCLES + 1);
  localparam int ROW_W  = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [WARM_W-1:0] warm_cnt;
  logic [COL_W-1:0]  col_cnt;
  logic [ROW_W-1:0]  row_cnt;
  logic              row_seen;

  // warm-up count restarts whenever the sequencer leaves WARMUP
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      warm_cnt <= '0;
    end else if (i_warm_en) begin
      warm_cnt <= warm_cnt + 1'b1;
    end else begin
      warm_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
    end else if (i_row_load) begin
      col_cnt <= '0;
    end else if (i_col_en) begin
      col_cnt <= (col_cnt == COL_W'(COLS - 1)) ? '0 : col_cnt + 1'b1;
    end
  end

  // first row load of a frame keeps row 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt  <= '0;
      row_seen <= 1'b0;
    end else if (i_warm_en) begin
      row_cnt  <= '0;
      row_seen <= 1'b0;
    end else if (i_row_load) begin
      row_seen <= 1'b1;
      if (row_seen) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  assign o_warm_done = (warm_cnt == WARM_W'(box_pkg::WARMUP_CYCLES - 1));
  assign o_col       = col_cnt;
  assign o_last_row  = (row_cnt == ROW_W'(ROWS - 1));
  assign o_rd_addr   = ADDR_W'(row_cnt * COLS) + ADDR_W'(col_cnt);

  a_col_range : assert property (@(posedge clk) disable iff (!rst_n)
    col_cnt <= COL_W'(COLS - 1));

endmodule

//--- src/pixel_unpack.sv
module pixel_unpack #(
  parameter int LANES = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [LANES*box_pkg::PIX_W-1:0]       i_rd_data,
  input  logic                                  i_row_load,
  input  logic                                  i_fill,
  input  logic                                  i_slide,
  input  logic                                  i_row_last_col,
  output logic [LANES-1:0][box_pkg::PIX_W-1:0]  o_lane_pix,
  output logic                                  o_clr,
  output logic                                  o_push,
  output logic                                  o_emit,
  output logic                                  o_last
);

  // lane 0 sits in the low byte
  for (genvar g = 0; g < LANES; g++) begin : g_slice
    assign o_lane_pix[g] = i_rd_data[g*box_pkg::PIX_W +: box_pkg::PIX_W];
  end

  // strobes follow the read by one cycle, same as the buffer data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_clr  <= 1'b0;
      o_push <= 1'b0;
      o_emit <= 1'b0;
      o_last <= 1'b0;
    end else begin
      o_clr  <= i_row_load;
      o_push <= i_fill | i_slide;
      o_emit <= i_slide;
      o_last <= i_row_last_col;
    end
  end

endmodule

//--- src/window_accum.sv
module window_accum #(
  parameter int WIN = 4,
  localparam int SUM_W = box_pkg::PIX_W + $clog2(WIN)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [box_pkg::PIX_W-1:0] i_pix,
  input  logic                      i_clr,
  input  logic                      i_push,
  input  logic                      i_emit,
  output logic [SUM_W-1:0]          o_sum,
  output logic                      o_sum_valid
);

  // hist[0] is the newest pixel, hist[WIN-1] the one about to leave
  logic [box_pkg::PIX_W-1:0] hist [WIN];
  logic [SUM_W-1:0]          sum;

  // cleared history reads as zero while the window is still filling,
  // so the subtract below needs no fill count
  always_ff @(posedge clk) begin
    if (i_clr) begin
      for (int i = 0; i < WIN; i++) begin
        hist[i] <= '0;
      end
    end else if (i_push) begin
      hist[0] <= i_pix;
      for (int i = 1; i < WIN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // add newest, drop oldest
  // may wrap in between, final value always fits
  always_ff @(posedge clk) begin
    if (i_clr) begin
      sum <= '0;
    end else if (i_push) begin
      sum <= sum + SUM_W'(i_pix) - SUM_W'(hist[WIN-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_sum_valid <= 1'b0;
    end else begin
      o_sum_valid <= i_emit;
    end
  end

  assign o_sum = sum;

  a_emit_with_push : assert property (@(posedge clk) disable iff (!rst_n)
    i_emit |-> i_push && !i_clr);

endmodule

//--- src/sum_pack.sv
module sum_pack #(
  parameter int LANES = 3,
  parameter int WIN   = 4,
  localparam int SUM_W = box_pkg::PIX_W + $clog2(WIN)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [LANES-1:0][SUM_W-1:0] i_lane_sum,
  input  logic [LANES-1:0]            i_lane_valid,
  input  logic                        i_last,
  output logic [LANES*SUM_W-1:0]      o_sum_data,
  output logic                        o_sum_valid,
  output logic                        o_row_end
);

  logic lanes_valid;
  logic last_q;

  assign lanes_valid = &i_lane_valid;

  // data word only moves with a valid set of sums
  always_ff @(posedge clk) begin
    if (lanes_valid) begin
      o_sum_data <= i_lane_sum;
    end
  end

  // last flag arrives with the pixel, one stage ahead of the lane sums
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q      <= 1'b0;
      o_sum_valid <= 1'b0;
      o_row_end   <= 1'b0;
    end else begin
      last_q      <= i_last;
      o_sum_valid <= lanes_valid;
      o_row_end   <= last_q;
    end
  end

  a_lanes_agree : assert property (@(posedge clk) disable iff (!rst_n)
    (&i_lane_valid) || !(|i_lane_valid));

endmodule

//--- src/box_filter_top.sv
module box_filter_top #(
  parameter int COLS  = 16,
  parameter int ROWS  = 4,
  parameter int WIN   = 4,
  parameter int LANES = 3,
  localparam int SUM_W  = box_pkg::PIX_W + $clog2(WIN),
  localparam int ADDR_W = $clog2(ROWS * COLS)
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            i_start,
  input  logic [LANES*box_pkg::PIX_W-1:0] i_rd_data,
  output logic                            o_rd_en,
  output logic [ADDR_W-1:0]               o_rd_addr,
  output logic                            o_sum_valid,
  output logic [LANES*SUM_W-1:0]          o_sum_data,
  output logic                            o_row_end,
  output logic                            o_frame_done
);

  localparam int COL_W = $clog2(COLS);

  logic                                 warm_en;
  logic                                 warm_done;
  logic                                 col_en;
  logic                                 row_load;
  logic                                 fill;
  logic                                 slide;
  logic                                 row_last_col;
  logic [COL_W-1:0]                     col;
  logic                                 last_row;
  logic [LANES-1:0][box_pkg::PIX_W-1:0] lane_pix;
  logic                                 clr;
  logic                                 push;
  logic                                 emit;
  logic                                 last;
  logic [LANES-1:0][SUM_W-1:0]          lane_sum;
  logic [LANES-1:0]                     lane_valid;

  assign o_rd_en = col_en;

  row_sequencer #(.COLS(COLS), .ROWS(ROWS), .WIN(WIN)) u_seq (
    .clk(clk), .rst_n(rst_n), .i_start(i_start), .i_warm_done(warm_done),
    .i_col(col), .i_last_row(last_row), .o_warm_en(warm_en), .o_col_en(col_en),
    .o_row_load(row_load), .o_fill(fill), .o_slide(slide),
    .o_row_last_col(row_last_col), .o_frame_done(o_frame_done)
  );

  scan_counter #(.COLS(COLS), .ROWS(ROWS)) u_scan (
    .clk(clk), .rst_n(rst_n), .i_warm_en(warm_en), .i_col_en(col_en),
    .i_row_load(row_load), .o_warm_done(warm_done), .o_col(col),
    .o_last_row(last_row), .o_rd_addr(o_rd_addr)
  );

  pixel_unpack #(.LANES(LANES)) u_unpack (
    .clk(clk), .rst_n(rst_n), .i_rd_data(i_rd_data), .i_row_load(row_load),
    .i_fill(fill), .i_slide(slide), .i_row_last_col(row_last_col),
    .o_lane_pix(lane_pix), .o_clr(clr), .o_push(push), .o_emit(emit), .o_last(last)
  );

  // one accumulator per color channel
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    window_accum #(.WIN(WIN)) u_accum (
      .clk(clk), .rst_n(rst_n), .i_pix(lane_pix[g]), .i_clr(clr), .i_push(push),
      .i_emit(emit), .o_sum(lane_sum[g]), .o_sum_valid(lane_valid[g])
    );
  end

  sum_pack #(.LANES(LANES), .WIN(WIN)) u_pack (
    .clk(clk), .rst_n(rst_n), .i_lane_sum(lane_sum), .i_lane_valid(lane_valid),
    .i_last(last), .o_sum_data(o_sum_data), .o_sum_valid(o_sum_valid),
    .o_row_end(o_row_end)
  );

endmodule

//--- testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// packed output word, lane 0 in the low bits
task automatic check_sum(input string name, input logic [OUT_W-1:0] got,
                         input logic [OUT_W-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
  end
endtask

task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                          input logic [ADDR_W-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
  end
endtask

// plain sum of the WIN pixels ending at col, one sum per lane
task automatic model_window(input int row, input int col, output logic [OUT_W-1:0] exp);
  logic [SUM_W-1:0] acc;
  logic [PW-1:0]    word;
  exp = '0;
  for (int l = 0; l < LANES; l++) begin
    acc = '0;
    for (int c = col - WIN + 1; c <= col; c++) begin
      word = frame[ADDR_W'(row * COLS + c)];
      acc  = acc + SUM_W'(PIX'(word >> (l * PIX)));
    end
    exp = exp | (OUT_W'(acc) << (l * SUM_W));
  end
endtask

`endif

//--- testbench/tb_box_filter.sv
module tb_box_filter;

  localparam int COLS     = 16;
  localparam int ROWS     = 4;
  localparam int WIN      = 4;
  localparam int LANES    = 3;
  localparam int PIX      = box_pkg::PIX_W;
  localparam int PW       = LANES * PIX;
  localparam int SUM_W    = PIX + $clog2(WIN);
  localparam int OUT_W    = LANES * SUM_W;
  localparam int ADDR_W   = $clog2(ROWS * COLS);
  localparam int NOUT_ROW = COLS - WIN + 1;
  localparam int NOUT     = ROWS * NOUT_ROW;
  // five full frames plus the one cut by reset
  localparam int FRAMES   = 6;
  localparam int LIMIT    = FRAMES * (ROWS * (COLS + 2) + 10) + 200;

  logic              clk;
  logic              rst_n;
  logic              i_start;
  logic [PW-1:0]     i_rd_data;
  logic              o_rd_en;
  logic [ADDR_W-1:0] o_rd_addr;
  logic              o_sum_valid;
  logic [OUT_W-1:0]  o_sum_data;
  logic              o_row_end;
  logic              o_frame_done;

  logic [PW-1:0]     frame [ROWS*COLS];
  logic [OUT_W-1:0]  out_q [$];
  logic              end_q [$];
  logic [ADDR_W-1:0] rd_q [$];
  int                done_count = 0;
  int                done_cycle = 0;
  int                last_rd_cycle = 0;
  int                cycles = 0;
  int                seed = 32'h49ca;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  box_filter_top #(.COLS(COLS), .ROWS(ROWS), .WIN(WIN), .LANES(LANES)) i_dut (
    .clk(clk), .rst_n(rst_n), .i_start(i_start), .i_rd_data(i_rd_data),
    .o_rd_en(o_rd_en), .o_rd_addr(o_rd_addr), .o_sum_valid(o_sum_valid),
    .o_sum_data(o_sum_data), .o_row_end(o_row_end), .o_frame_done(o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // frame buffer, one cycle read latency
  always @(posedge clk) begin
    if (o_rd_en) begin
      i_rd_data <= frame[o_rd_addr];
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (o_rd_en) begin
        rd_q.push_back(o_rd_addr);
        last_rd_cycle = cycles;
      end
      if (o_sum_valid) begin
        out_q.push_back(o_sum_data);
        end_q.push_back(o_row_end);
      end
      if (o_row_end && !o_sum_valid) begin
        abort_run("o_row_end was high without o_sum_valid");
      end
      if (o_frame_done) begin
        done_count++;
        done_cycle = cycles;
      end
    end
  end

  always @(posedge clk) begin : b_timeout
    box_pkg::seq_state_t st;
    st = i_dut.u_seq.state;
    if (cycles >= LIMIT) begin
      abort_run($sformatf("timeout: run passed %0d cycles, sequencer in %s", LIMIT, st.name()));
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic pulse_start();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    @(negedge clk);
  endtask

  // no strobe may show while the engine is idle or held in reset
  task automatic idle_check(input int n);
    repeat (n) begin
      @(negedge clk);
      check_bit("o_rd_en", o_rd_en, 1'b0);
      check_bit("o_sum_valid", o_sum_valid, 1'b0);
      check_bit("o_row_end", o_row_end, 1'b0);
      check_bit("o_frame_done", o_frame_done, 1'b0);
    end
  endtask

  task automatic fill_frame(input int kind);
    logic [PW-1:0] word;
    for (int a = 0; a < ROWS * COLS; a++) begin
      word = '0;
      for (int l = 0; l < LANES; l++) begin
        word = word | (PW'(PIX'(a + l * 64)) << (l * PIX));
      end
      if (kind == 1) begin
        word = PW'($random(seed));
      end else if (kind == 2) begin
        word = '1;
      end
      frame[ADDR_W'(a)] = word;
    end
  endtask

  task automatic check_frame(input string label);
    logic [OUT_W-1:0] exp;
    if (rd_q.size() != ROWS * COLS) begin
      abort_run($sformatf("%s: %0d reads seen, %0d expected", label, rd_q.size(), ROWS * COLS));
    end
    for (int k = 0; k < ROWS * COLS; k++) begin
      check_addr($sformatf("%s o_rd_addr[%0d]", label, k), rd_q[k], ADDR_W'(k));
    end
    if (out_q.size() != NOUT) begin
      abort_run($sformatf("%s: %0d output words seen, %0d expected", label, out_q.size(), NOUT));
    end
    for (int k = 0; k < NOUT; k++) begin
      model_window(k / NOUT_ROW, WIN - 1 + k % NOUT_ROW, exp);
      check_sum($sformatf("%s o_sum_data[%0d]", label, k), out_q[k], exp);
      check_bit($sformatf("%s o_row_end[%0d]", label, k), end_q[k],
                (k % NOUT_ROW) == (NOUT_ROW - 1));
    end
    if (done_count != 1) begin
      abort_run($sformatf("%s: o_frame_done pulsed %0d times in one frame", label, done_count));
    end
    check_bit({label, " o_frame_done after last read"}, done_cycle > last_rd_cycle, 1'b1);
  endtask

  // restart_at > 0 gives a second start after that many reads
  task automatic run_frame(input string label, input int restart_at);
    out_q.delete();
    end_q.delete();
    rd_q.delete();
    done_count = 0;
    pulse_start();
    if (restart_at > 0) begin
      while (rd_q.size() < restart_at) @(negedge clk);
      pulse_start();
    end
    while (done_count == 0) @(negedge clk);
    while (out_q.size() < NOUT) @(negedge clk);
    idle_check(4);
    check_frame(label);
  endtask

  task automatic test_reset_mid_frame();
    fill_frame(1);
    out_q.delete();
    pulse_start();
    while (out_q.size() < 5) @(negedge clk);
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    repeat (7) begin
      idle_check(1);
      @(posedge clk);
    end
    rst_n <= 1'b1;
    idle_check(3);
    run_frame("after reset", 0);
  endtask

  initial begin
    rst_n     = 1'b0;
    i_start   = 1'b0;
    i_rd_data = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    idle_check(6);
    fill_frame(0);
    run_frame("ramp", 0);
    fill_frame(1);
    run_frame("random", 0);
    fill_frame(2);
    run_frame("all 255", 0);
    fill_frame(1);
    run_frame("start mid-frame", 30);
    test_reset_mid_frame();
    $display("Test OK");
    $finish;
  end

endmodule

//--- sim.f
+incdir+testbench
src/box_pkg.sv
src/row_sequencer.sv
src/scan_counter.sv
src/pixel_unpack.sv
src/window_accum.sv
src/sum_pack.sv
src/box_filter_top.sv
testbench/tb_box_filter.sv

//--- Makefile
TOP = tb_box_filter

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)
	verilator --lint-only --assert src/box_pkg.sv src/row_sequencer.sv \
	  src/scan_counter.sv src/pixel_unpack.sv src/window_accum.sv \
	  src/sum_pack.sv src/box_filter_top.sv --top-module box_filter_top

clean:
	rm -rf obj_dir sim.log
